// File: source/filter_pkg.sv
/* Opcodes and field-state codes shared by the filter-condition stages.
   Opcodes above FILTER_NOT_EQ_TERN are undefined; state codes 2 and 3 pass through untouched. */
package filter_pkg;

  // --------------------------------------------------
  // Operation codes
  // --------------------------------------------------
  localparam int unsigned FILTER_OP_WIDTH = 4;

  // No operation, operands go straight out
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_NOP         = 4'd0;

  // Ring compares, one flag per field
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_GT          = 4'd1;
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_LT          = 4'd2;
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_EQ          = 4'd3;
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_NOT_EQ      = 4'd4;

  // Ternary reorders on operands 0, 1 and the last slot
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_GT_TERN     = 4'd5;
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_LT_TERN     = 4'd6;
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_EQ_TERN     = 4'd7;
  localparam logic [FILTER_OP_WIDTH-1:0] FILTER_NOT_EQ_TERN = 4'd8;

  // --------------------------------------------------
  // Field state codes
  // --------------------------------------------------
  localparam int unsigned FIELD_STATE_WIDTH = 2;

  // Slot holds no usable value
  localparam logic [FIELD_STATE_WIDTH-1:0] FIELD_STATE_INVALID = 2'd0;
  // Slot holds a live value
  localparam logic [FIELD_STATE_WIDTH-1:0] FIELD_STATE_RUNNING = 2'd1;

endpackage : filter_pkg

// File: source/filter_operand_select.sv
/* Stage 1, one register deep. Each ops_mask row must be zero or one-hot;
   const_mask wins over routing for a slot. */
module filter_operand_select #(
  parameter int NUM_FIELDS  = 4,
  parameter int FIELD_WIDTH = 32
) (
  input  logic                                                ap_clk,
  input  logic                                                rst,
  input  logic                                                in_valid,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   field_data,
  input  logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] field_state,
  input  logic [NUM_FIELDS-1:0]                               const_mask,
  input  logic [FIELD_WIDTH-1:0]                              const_value,
  input  logic [NUM_FIELDS*NUM_FIELDS-1:0]                    ops_mask,
  input  logic [NUM_FIELDS-1:0]                               filter_mask,
  input  logic [filter_pkg::FILTER_OP_WIDTH-1:0]              filter_operation,
  input  logic                                                equal_flag,
  output logic                                                sel_valid,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   ops_data,
  output logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] ops_state,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   orig_data,
  output logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] orig_state,
  output logic [NUM_FIELDS-1:0]                               sel_filter_mask,
  output logic [filter_pkg::FILTER_OP_WIDTH-1:0]              sel_filter_operation,
  output logic                                                sel_equal_flag
);

  import filter_pkg::*;

  logic [NUM_FIELDS*FIELD_WIDTH-1:0]       ops_data_next;
  logic [NUM_FIELDS*FIELD_STATE_WIDTH-1:0] ops_state_next;
  logic [NUM_FIELDS*FIELD_WIDTH-1:0]       orig_data_next;
  logic [NUM_FIELDS*FIELD_STATE_WIDTH-1:0] orig_state_next;
  logic [NUM_FIELDS-1:0]                   rows_onehot0;

  // --------------------------------------------------
  // Slot routing
  // --------------------------------------------------
  always_comb begin
    logic [NUM_FIELDS-1:0]        row;
    logic [FIELD_WIDTH-1:0]       pick_data;
    logic [FIELD_STATE_WIDTH-1:0] pick_state;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      row = ops_mask[i*NUM_FIELDS +: NUM_FIELDS];
      rows_onehot0[i] = ((row & (row - 1'b1)) == '0);

      // Own field unless the row routes another one in
      pick_data  = field_data[i*FIELD_WIDTH +: FIELD_WIDTH];
      pick_state = field_state[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH];
      for (int j = 0; j < NUM_FIELDS; j++) begin
        if (row[j]) begin
          pick_data  = field_data[j*FIELD_WIDTH +: FIELD_WIDTH];
          pick_state = field_state[j*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH];
        end
      end

      orig_data_next[i*FIELD_WIDTH +: FIELD_WIDTH]              = pick_data;
      orig_state_next[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH] = pick_state;

      if (const_mask[i]) begin
        ops_data_next[i*FIELD_WIDTH +: FIELD_WIDTH]              = const_value;
        ops_state_next[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH] = FIELD_STATE_RUNNING;
      end else if (|row) begin
        ops_data_next[i*FIELD_WIDTH +: FIELD_WIDTH]              = pick_data;
        ops_state_next[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH] = pick_state;
      end else begin
        // Unrouted slot reads as an empty operand
        ops_data_next[i*FIELD_WIDTH +: FIELD_WIDTH]              = '0;
        ops_state_next[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH] = FIELD_STATE_INVALID;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      sel_valid <= 1'b0;
    end else begin
      sel_valid <= in_valid;
    end
  end

  // Packet and configuration move on every cycle
  always_ff @(posedge ap_clk) begin
    ops_data             <= ops_data_next;
    ops_state            <= ops_state_next;
    orig_data            <= orig_data_next;
    orig_state           <= orig_state_next;
    sel_filter_mask      <= filter_mask;
    sel_filter_operation <= filter_operation;
    sel_equal_flag       <= equal_flag;
  end

  // Two bits in one row would make the routed source ambiguous
  ops_mask_onehot0_a : assert property (@(posedge ap_clk) disable iff (rst)
    in_valid |-> &rows_onehot0)
    else $error("ops_mask row with more than one source bit");

endmodule : filter_operand_select

// File: source/filter_cond_eval.sv
/* Stage 2, one register deep. Compares are unsigned against the ring neighbour;
   undefined opcodes return the orig set with all flags set. */
module filter_cond_eval #(
  parameter int NUM_FIELDS  = 4,
  parameter int FIELD_WIDTH = 32
) (
  input  logic                                                ap_clk,
  input  logic                                                rst,
  input  logic                                                sel_valid,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   ops_data,
  input  logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] ops_state,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   orig_data,
  input  logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] orig_state,
  input  logic [NUM_FIELDS-1:0]                               sel_filter_mask,
  input  logic [filter_pkg::FILTER_OP_WIDTH-1:0]              sel_filter_operation,
  input  logic                                                sel_equal_flag,
  output logic                                                eval_valid,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   res_data,
  output logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] res_state,
  output logic [NUM_FIELDS-1:0]                               cond_flags,
  output logic [NUM_FIELDS-1:0]                               eval_filter_mask
);

  import filter_pkg::*;

  localparam int LAST = NUM_FIELDS - 1;

  logic [FIELD_WIDTH-1:0]       op_d  [NUM_FIELDS];
  logic [FIELD_STATE_WIDTH-1:0] op_s  [NUM_FIELDS];
  logic [FIELD_WIDTH-1:0]       org_d [NUM_FIELDS];
  logic [FIELD_STATE_WIDTH-1:0] org_s [NUM_FIELDS];
  logic [FIELD_WIDTH-1:0]       res_d [NUM_FIELDS];
  logic [FIELD_STATE_WIDTH-1:0] res_s [NUM_FIELDS];

  logic [NUM_FIELDS-1:0] gt;
  logic [NUM_FIELDS-1:0] lt;
  logic [NUM_FIELDS-1:0] eq;
  logic [NUM_FIELDS-1:0] eq_mask;
  logic [NUM_FIELDS-1:0] flags_next;
  logic                  keep_order;
  logic                  swap_ends;

  // Slice the flat packets into per-field views
  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      op_d[i]  = ops_data[i*FIELD_WIDTH +: FIELD_WIDTH];
      op_s[i]  = ops_state[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH];
      org_d[i] = orig_data[i*FIELD_WIDTH +: FIELD_WIDTH];
      org_s[i] = orig_state[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH];
    end
  end

  // --------------------------------------------------
  // Neighbour compares, last field wraps to field 0
  // --------------------------------------------------
  always_comb begin
    int nb;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      nb = (i == LAST) ? 0 : i + 1;
      gt[i] = op_d[i] > op_d[nb];
      lt[i] = op_d[i] < op_d[nb];
      eq[i] = op_d[i] == op_d[nb];
    end
  end

  // Or-equal term for GT and LT
  assign eq_mask = eq & {NUM_FIELDS{sel_equal_flag}};

  // Ternary conditions only look at slots 0 and 1
  always_comb begin
    keep_order = 1'b1;
    swap_ends  = 1'b0;
    case (sel_filter_operation)
      FILTER_GT_TERN:     keep_order = gt[0] | eq_mask[0];
      FILTER_LT_TERN:     keep_order = lt[0] | eq_mask[0];
      FILTER_EQ_TERN:     swap_ends  = eq[0];
      FILTER_NOT_EQ_TERN: swap_ends  = ~eq[0];
      default:            keep_order = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // Result selection
  // --------------------------------------------------
  always_comb begin
    flags_next = '1;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      res_d[i] = org_d[i];
      res_s[i] = org_s[i];
    end

    case (sel_filter_operation)
      FILTER_GT:     flags_next = gt | eq_mask;
      FILTER_LT:     flags_next = lt | eq_mask;
      FILTER_EQ:     flags_next = eq;
      FILTER_NOT_EQ: flags_next = ~eq;

      FILTER_NOP, FILTER_GT_TERN, FILTER_LT_TERN,
      FILTER_EQ_TERN, FILTER_NOT_EQ_TERN: begin
        for (int i = 0; i < NUM_FIELDS; i++) begin
          res_d[i] = op_d[i];
          res_s[i] = op_s[i];
        end
        // State moves along with its data
        if (!keep_order) begin
          res_d[0] = op_d[1];
          res_s[0] = op_s[1];
          res_d[1] = op_d[0];
          res_s[1] = op_s[0];
        end
        if (swap_ends) begin
          res_d[0]    = op_d[LAST];
          res_s[0]    = op_s[LAST];
          res_d[LAST] = op_d[0];
          res_s[LAST] = op_s[0];
        end
      end

      default: flags_next = '1;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      eval_valid <= 1'b0;
    end else begin
      eval_valid <= sel_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      res_data[i*FIELD_WIDTH +: FIELD_WIDTH]              <= res_d[i];
      res_state[i*FIELD_STATE_WIDTH +: FIELD_STATE_WIDTH] <= res_s[i];
    end
    cond_flags       <= flags_next;
    eval_filter_mask <= sel_filter_mask;
  end

  // Undefined codes still produce a packet, flag them for the user
  filter_op_defined_a : assert property (@(posedge ap_clk) disable iff (rst)
    sel_valid |-> sel_filter_operation <= FILTER_NOT_EQ_TERN)
    else $warning("undefined filter_operation %0d", sel_filter_operation);

endmodule : filter_cond_eval

// File: source/filter_result_reduce.sv
/* Stage 3, one register deep. A zero filter_mask always passes. */
module filter_result_reduce #(
  parameter int NUM_FIELDS  = 4,
  parameter int FIELD_WIDTH = 32
) (
  input  logic                                                ap_clk,
  input  logic                                                rst,
  input  logic                                                eval_valid,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   res_data,
  input  logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] res_state,
  input  logic [NUM_FIELDS-1:0]                               cond_flags,
  input  logic [NUM_FIELDS-1:0]                               eval_filter_mask,
  output logic                                                out_valid,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   out_data,
  output logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] out_state,
  output logic                                                pass
);

  logic pass_next;

  // Masked-off fields count as passing
  assign pass_next = &(cond_flags | ~eval_filter_mask);

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= eval_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_data  <= res_data;
    out_state <= res_state;
    pass      <= pass_next;
  end

  // No stray packet right out of reset
  out_valid_after_rst_a : assert property (@(posedge ap_clk)
    $fell(rst) |=> !out_valid)
    else $error("out_valid high in the cycle after reset release");

endmodule : filter_result_reduce

// File: source/filter_cond_engine.sv
/* Fixed three-cycle pipeline with one packet per cycle and no back-pressure;
   the sink must take every out_valid. */
module filter_cond_engine #(
  parameter int NUM_FIELDS  = 4,
  parameter int FIELD_WIDTH = 32
) (
  input  logic                                                ap_clk,
  input  logic                                                rst,
  input  logic                                                in_valid,
  input  logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   field_data,
  input  logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] field_state,
  input  logic [NUM_FIELDS-1:0]                               const_mask,
  input  logic [FIELD_WIDTH-1:0]                              const_value,
  input  logic [NUM_FIELDS*NUM_FIELDS-1:0]                    ops_mask,
  input  logic [NUM_FIELDS-1:0]                               filter_mask,
  input  logic [filter_pkg::FILTER_OP_WIDTH-1:0]              filter_operation,
  input  logic                                                equal_flag,
  output logic                                                out_valid,
  output logic [NUM_FIELDS*FIELD_WIDTH-1:0]                   out_data,
  output logic [NUM_FIELDS*filter_pkg::FIELD_STATE_WIDTH-1:0] out_state,
  output logic                                                pass
);

  import filter_pkg::*;

  // Stage 1 to stage 2
  logic                                    sel_valid;
  logic [NUM_FIELDS*FIELD_WIDTH-1:0]       ops_data;
  logic [NUM_FIELDS*FIELD_STATE_WIDTH-1:0] ops_state;
  logic [NUM_FIELDS*FIELD_WIDTH-1:0]       orig_data;
  logic [NUM_FIELDS*FIELD_STATE_WIDTH-1:0] orig_state;
  logic [NUM_FIELDS-1:0]                   sel_filter_mask;
  logic [FILTER_OP_WIDTH-1:0]              sel_filter_operation;
  logic                                    sel_equal_flag;

  // Stage 2 to stage 3
  logic                                    eval_valid;
  logic [NUM_FIELDS*FIELD_WIDTH-1:0]       res_data;
  logic [NUM_FIELDS*FIELD_STATE_WIDTH-1:0] res_state;
  logic [NUM_FIELDS-1:0]                   cond_flags;
  logic [NUM_FIELDS-1:0]                   eval_filter_mask;

  filter_operand_select #(
    .NUM_FIELDS (NUM_FIELDS),
    .FIELD_WIDTH(FIELD_WIDTH)
  ) operand_select_i (
    .ap_clk, .rst, .in_valid, .field_data, .field_state,
    .const_mask, .const_value, .ops_mask, .filter_mask,
    .filter_operation, .equal_flag,
    .sel_valid, .ops_data, .ops_state, .orig_data, .orig_state,
    .sel_filter_mask, .sel_filter_operation, .sel_equal_flag
  );

  filter_cond_eval #(
    .NUM_FIELDS (NUM_FIELDS),
    .FIELD_WIDTH(FIELD_WIDTH)
  ) cond_eval_i (
    .ap_clk, .rst, .sel_valid, .ops_data, .ops_state, .orig_data, .orig_state,
    .sel_filter_mask, .sel_filter_operation, .sel_equal_flag,
    .eval_valid, .res_data, .res_state, .cond_flags, .eval_filter_mask
  );

  filter_result_reduce #(
    .NUM_FIELDS (NUM_FIELDS),
    .FIELD_WIDTH(FIELD_WIDTH)
  ) result_reduce_i (
    .ap_clk, .rst, .eval_valid, .res_data, .res_state, .cond_flags,
    .eval_filter_mask,
    .out_valid, .out_data, .out_state, .pass
  );

endmodule : filter_cond_engine

// File: verif/filter_clock_gen.sv
/* Free-running 4 ns clock. rst is held high over the first RESET_CYCLES rising edges
   and drops 1 ns after the last one. */
module filter_clock_gen #(
  parameter int RESET_CYCLES = 3
) (
  output logic ap_clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // Release with the same skew as the stimulus
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #1 rst = 1'b0;
  end

endmodule : filter_clock_gen

// File: verif/filter_cond_engine_tb.sv
/* Table-driven testbench for the default 4 x 32 engine. Expected values are
   written by hand per entry; entries go in back to back, one per cycle. */
module filter_cond_engine_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import filter_pkg::*;

  localparam int NF             = 4;
  localparam int FW             = 32;
  localparam int SW             = FIELD_STATE_WIDTH;
  localparam int NUM_ENTRIES    = 22;
  localparam int LATENCY        = 3;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES + LATENCY + 20;

  // Each hex digit is one ops_mask row, slot i routes field i
  localparam logic [NF*NF-1:0] IDENT = 16'h8421;

  localparam logic [SW-1:0] INV = FIELD_STATE_INVALID;
  localparam logic [SW-1:0] RUN = FIELD_STATE_RUNNING;
  localparam logic [SW-1:0] S2  = 2'd2;
  localparam logic [SW-1:0] S3  = 2'd3;

  logic                       ap_clk;
  logic                       rst;
  logic                       in_valid;
  logic [NF*FW-1:0]           field_data;
  logic [NF*SW-1:0]           field_state;
  logic [NF-1:0]              const_mask;
  logic [FW-1:0]              const_value;
  logic [NF*NF-1:0]           ops_mask;
  logic [NF-1:0]              filter_mask;
  logic [FILTER_OP_WIDTH-1:0] filter_operation;
  logic                       equal_flag;
  logic                       out_valid;
  logic [NF*FW-1:0]           out_data;
  logic [NF*SW-1:0]           out_state;
  logic                       pass;

  // Stimulus and expected table
  string                      tbl_name        [NUM_ENTRIES];
  logic [NF*FW-1:0]           tbl_data        [NUM_ENTRIES];
  logic [NF*SW-1:0]           tbl_state       [NUM_ENTRIES];
  logic [NF-1:0]              tbl_const_mask  [NUM_ENTRIES];
  logic [FW-1:0]              tbl_const_value [NUM_ENTRIES];
  logic [NF*NF-1:0]           tbl_ops_mask    [NUM_ENTRIES];
  logic [NF-1:0]              tbl_filter_mask [NUM_ENTRIES];
  logic [FILTER_OP_WIDTH-1:0] tbl_op          [NUM_ENTRIES];
  logic                       tbl_equal_flag  [NUM_ENTRIES];
  logic [NF*FW-1:0]           tbl_exp_data    [NUM_ENTRIES];
  logic [NF*SW-1:0]           tbl_exp_state   [NUM_ENTRIES];
  logic                       tbl_exp_pass    [NUM_ENTRIES];

  int n_entries = 0;
  int cyc       = 0;
  int errors    = 0;
  int checked   = 0;
  int pend_idx [$];
  int pend_cyc [$];

  filter_clock_gen #(.RESET_CYCLES(3)) clock_gen_i (.ap_clk, .rst);

  filter_cond_engine dut_i (
    .ap_clk, .rst, .in_valid, .field_data, .field_state,
    .const_mask, .const_value, .ops_mask, .filter_mask,
    .filter_operation, .equal_flag,
    .out_valid, .out_data, .out_state, .pass
  );

  // --------------------------------------------------
  // Table building helpers
  // --------------------------------------------------
  function automatic logic [NF*FW-1:0] words(input logic [FW-1:0] w0, w1, w2, w3);
    return {w3, w2, w1, w0};
  endfunction

  function automatic logic [NF*SW-1:0] states(input logic [SW-1:0] s0, s1, s2, s3);
    return {s3, s2, s1, s0};
  endfunction

  task automatic add_entry(input string name, input logic [NF*FW-1:0] data,
                           input logic [NF*SW-1:0] state, input logic [NF-1:0] cmask,
                           input logic [FW-1:0] cvalue, input logic [NF*NF-1:0] omask,
                           input logic [NF-1:0] fmask, input logic [FILTER_OP_WIDTH-1:0] op,
                           input logic eqf, input logic [NF*FW-1:0] exp_data,
                           input logic [NF*SW-1:0] exp_state, input logic exp_pass);
    tbl_name[n_entries]        = name;
    tbl_data[n_entries]        = data;
    tbl_state[n_entries]       = state;
    tbl_const_mask[n_entries]  = cmask;
    tbl_const_value[n_entries] = cvalue;
    tbl_ops_mask[n_entries]    = omask;
    tbl_filter_mask[n_entries] = fmask;
    tbl_op[n_entries]          = op;
    tbl_equal_flag[n_entries]  = eqf;
    tbl_exp_data[n_entries]    = exp_data;
    tbl_exp_state[n_entries]   = exp_state;
    tbl_exp_pass[n_entries]    = exp_pass;
    n_entries++;
  endtask

  // Compares return the orig set, which equals the input under IDENT routing
  task automatic add_compare(input string name, input logic [NF*FW-1:0] data,
                             input logic [NF*SW-1:0] state, input logic [NF-1:0] fmask,
                             input logic [FILTER_OP_WIDTH-1:0] op, input logic eqf,
                             input logic exp_pass);
    add_entry(name, data, state, 4'b0000, 32'h0, IDENT, fmask, op, eqf, data, state, exp_pass);
  endtask

  // Ternaries set every flag, so a full mask still passes
  task automatic add_ternary(input string name, input logic [NF*FW-1:0] data,
                             input logic [NF*SW-1:0] state,
                             input logic [FILTER_OP_WIDTH-1:0] op, input logic eqf,
                             input logic [NF*FW-1:0] exp_data, input logic [NF*SW-1:0] exp_state);
    add_entry(name, data, state, 4'b0000, 32'h0, IDENT, 4'b1111, op, eqf,
              exp_data, exp_state, 1'b1);
  endtask

  task automatic build_table();
    // Slot 0 constant, slot 1 from field 3, slot 2 unrouted, slot 3 from field 1
    add_entry("route_nop", words(32'h11, 32'h22, 32'h33, 32'h44), states(RUN, S2, S3, RUN),
              4'b0001, 32'hC0DE, 16'h2080, 4'b1111, FILTER_NOP, 1'b0,
              words(32'hC0DE, 32'h44, 32'h0, 32'h22), states(RUN, RUN, INV, S2), 1'b1);
    add_entry("route_const_mix", words(32'h100, 32'h200, 32'h300, 32'h400),
              states(S3, INV, S2, RUN), 4'b1010, 32'hABCD, IDENT, 4'b0101, FILTER_NOP, 1'b0,
              words(32'h100, 32'hABCD, 32'h300, 32'hABCD), states(S3, RUN, S2, RUN), 1'b1);

    add_compare("gt_masked_wrap", words(40, 30, 20, 10), states(RUN, RUN, S2, INV),
                4'b0111, FILTER_GT, 1'b0, 1'b1);
    add_compare("gt_wrap_fail", words(40, 30, 20, 10), states(RUN, RUN, RUN, RUN),
                4'b1111, FILTER_GT, 1'b0, 1'b0);
    add_compare("gt_or_equal", words(30, 30, 20, 20), states(RUN, S3, RUN, INV),
                4'b0111, FILTER_GT, 1'b1, 1'b1);
    add_compare("gt_strict", words(30, 30, 20, 20), states(RUN, S3, RUN, INV),
                4'b0111, FILTER_GT, 1'b0, 1'b0);
    add_compare("gt_unsigned", words(32'h8000_0000, 32'h7FFF_FFFF, 1, 0),
                states(RUN, RUN, RUN, RUN), 4'b0111, FILTER_GT, 1'b0, 1'b1);
    add_compare("lt_or_equal", words(5, 5, 7, 5), states(RUN, RUN, RUN, RUN),
                4'b1011, FILTER_LT, 1'b1, 1'b1);
    add_compare("lt_strict", words(5, 5, 7, 5), states(RUN, RUN, RUN, RUN),
                4'b1011, FILTER_LT, 1'b0, 1'b0);
    add_compare("eq_ignores_flag", words(9, 9, 9, 8), states(S2, RUN, RUN, RUN),
                4'b0111, FILTER_EQ, 1'b1, 1'b0);
    add_compare("eq_masked", words(9, 9, 9, 8), states(S2, RUN, RUN, RUN),
                4'b0011, FILTER_EQ, 1'b0, 1'b1);
    add_compare("not_eq_ring", words(1, 2, 1, 2), states(RUN, INV, RUN, S3),
                4'b1111, FILTER_NOT_EQ, 1'b1, 1'b1);
    // Constant in slot 0 differs from field 0, so only the orig set matches
    add_entry("zero_mask", words(1, 1, 1, 1), states(S2, RUN, RUN, RUN), 4'b0001, 32'h5,
              IDENT, 4'b0000, FILTER_NOT_EQ, 1'b0,
              words(1, 1, 1, 1), states(S2, RUN, RUN, RUN), 1'b1);

    add_ternary("gt_tern_keep", words(40, 40, 7, 8), states(RUN, S2, S3, INV), FILTER_GT_TERN,
                1'b1, words(40, 40, 7, 8), states(RUN, S2, S3, INV));
    add_ternary("gt_tern_swap", words(40, 50, 7, 8), states(RUN, S2, S3, INV), FILTER_GT_TERN,
                1'b1, words(50, 40, 7, 8), states(S2, RUN, S3, INV));
    add_ternary("lt_tern_keep", words(3, 4, 7, 8), states(RUN, S2, S3, INV), FILTER_LT_TERN,
                1'b0, words(3, 4, 7, 8), states(RUN, S2, S3, INV));
    add_ternary("lt_tern_swap", words(6, 4, 7, 8), states(RUN, S2, S3, INV), FILTER_LT_TERN,
                1'b0, words(4, 6, 7, 8), states(S2, RUN, S3, INV));
    add_ternary("eq_tern_swap", words(6, 6, 7, 8), states(RUN, S2, S3, INV), FILTER_EQ_TERN,
                1'b0, words(8, 6, 7, 6), states(INV, S2, S3, RUN));
    add_ternary("eq_tern_keep", words(6, 5, 7, 8), states(RUN, S2, S3, INV), FILTER_EQ_TERN,
                1'b0, words(6, 5, 7, 8), states(RUN, S2, S3, INV));
    add_ternary("neq_tern_swap", words(6, 5, 7, 8), states(RUN, S2, S3, INV),
                FILTER_NOT_EQ_TERN, 1'b0, words(8, 5, 7, 6), states(INV, S2, S3, RUN));
    add_ternary("neq_tern_keep", words(6, 6, 7, 8), states(RUN, S2, S3, INV),
                FILTER_NOT_EQ_TERN, 1'b0, words(6, 6, 7, 8), states(RUN, S2, S3, INV));

    // Code 12 returns the orig set, so slot 0 shows field 2 and the constant is unused
    add_entry("undefined_op", words(32'h10, 32'h20, 32'h30, 32'h40), states(RUN, S2, S3, INV),
              4'b0010, 32'hFFFF, 16'h0004, 4'b1111, 4'd12, 1'b0,
              words(32'h30, 32'h20, 32'h30, 32'h40), states(S3, S2, S3, INV), 1'b1);
  endtask

  // --------------------------------------------------
  // Driver
  // --------------------------------------------------
  task automatic idle_inputs();
    in_valid         = 1'b0;
    field_data       = '0;
    field_state      = '0;
    const_mask       = '0;
    const_value      = '0;
    ops_mask         = '0;
    filter_mask      = '0;
    filter_operation = FILTER_NOP;
    equal_flag       = 1'b0;
  endtask

  task automatic drive_entry(input int idx);
    in_valid         = 1'b1;
    field_data       = tbl_data[idx];
    field_state      = tbl_state[idx];
    const_mask       = tbl_const_mask[idx];
    const_value      = tbl_const_value[idx];
    ops_mask         = tbl_ops_mask[idx];
    filter_mask      = tbl_filter_mask[idx];
    filter_operation = tbl_op[idx];
    equal_flag       = tbl_equal_flag[idx];
    pend_idx.push_back(idx);
    pend_cyc.push_back(cyc);
  endtask

  always @(posedge ap_clk) begin
    cyc <= cyc + 1;
  end

  initial begin
    idle_inputs();
    build_table();
    @(negedge rst);
    @(posedge ap_clk);
    #1;
    for (int i = 0; i < n_entries; i++) begin
      drive_entry(i);
      @(posedge ap_clk);
      #1;
    end
    idle_inputs();

    while (pend_idx.size() != 0) @(negedge ap_clk);
    // A short quiet tail catches any stray out_valid
    repeat (2) @(negedge ap_clk);
    #1;

    $display("Checked %0d of %0d packets, %0d errors", checked, n_entries, errors);
    if (errors == 0 && checked == n_entries) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // --------------------------------------------------
  // Checker, sampled away from the active edge
  // --------------------------------------------------
  always @(negedge ap_clk) begin : check_outputs
    int idx;
    int born;
    if (out_valid) begin
      assert (pend_idx.size() != 0) else begin
        errors++;
        $display("out_valid high at cycle %0d with no packet in flight", cyc);
      end
      if (pend_idx.size() != 0) begin
        idx  = pend_idx.pop_front();
        born = pend_cyc.pop_front();
        checked++;
        assert (cyc - born == LATENCY) else begin
          errors++;
          $display("Packet %s came out %0d cycles after entry instead of %0d",
                   tbl_name[idx], cyc - born, LATENCY);
        end
        assert (out_data === tbl_exp_data[idx]) else begin
          errors++;
          $display("ERROR %s expected %h actual %h", tbl_name[idx], tbl_exp_data[idx], out_data);
        end
        assert (out_state === tbl_exp_state[idx]) else begin
          errors++;
          $display("ERROR %s expected %h actual %h", tbl_name[idx], tbl_exp_state[idx],
                   out_state);
        end
        assert (pass === tbl_exp_pass[idx]) else begin
          errors++;
          $display("ERROR %s expected %b actual %b", tbl_name[idx], tbl_exp_pass[idx], pass);
        end
      end
    end else if (pend_idx.size() != 0) begin
      // Oldest packet overdue means it was dropped
      assert (cyc - pend_cyc[0] <= LATENCY) else begin
        errors++;
        idx = pend_idx.pop_front();
        born = pend_cyc.pop_front();
        $display("Packet %s entered at cycle %0d and never came out", tbl_name[idx], born);
      end
    end
  end

  initial begin
    while (cyc < TIMEOUT_CYCLES) @(negedge ap_clk);
    $display("Timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule : filter_cond_engine_tb

// File: all.f
source/filter_pkg.sv
source/filter_operand_select.sv
source/filter_cond_eval.sv
source/filter_result_reduce.sv
source/filter_cond_engine.sv
verif/filter_clock_gen.sv
verif/filter_cond_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the filter-condition testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module filter_cond_engine_tb \
  -f all.f \
  -o filter_cond_engine_sim

sim_output=$(./obj_dir/filter_cond_engine_sim)
echo "${sim_output}"

if echo "${sim_output}" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
